// ==== Makefile ====
# Verilator build and run for the floor request controller

SIM = obj_dir/floor_request_sim

compile:
	verilator --binary --timing --assert -f floor_request.f \
		--top-module floor_request_tb -Mdir obj_dir -o floor_request_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: compile run clean

// ==== floor_request.f ====
rtl/floor_pkg.sv
rtl/dispatch_pkg.sv
rtl/request_latch.sv
rtl/request_queue.sv
rtl/dispatch_control.sv
rtl/floor_request_top.sv
test/floor_request_clock.sv
test/floor_request_assertions.sv
test/floor_request_tb.sv

// ==== rtl/dispatch_control.sv ====
// Dispatch FSM serving queued floors first come, first served.
// activate_elevator drops at once when power is lost or emergency is raised.
// Door permissions are registered and lag the buttons by one cycle.

`timescale 1ns/100ps

module dispatch_control (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              queue_empty,
    input  floor_pkg::floor_t head_floor,
    input  floor_pkg::floor_t current_floor,
    input  logic              elevator_moving,
    input  logic              power_switch,
    input  logic              emergency_button,
    input  logic              door_open_button,
    input  logic              door_close_button,
    output logic              pop,
    output logic              arrived,
    output floor_pkg::floor_t target_floor,
    output logic              direction_up,
    output logic              activate_elevator,
    output logic              door_open_allowed,
    output logic              door_close_allowed
);
    import dispatch_pkg::*;

    dispatch_state_t state;
    dispatch_state_t state_next;
    logic            enabled;
    logic            at_target;

    assign enabled   = power_switch && !emergency_button;
    assign at_target = (target_floor == current_floor);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (pop) begin
                    state_next = dispatch;
                end
            end
            dispatch: begin
                // Already there, nothing to move
                if (at_target) begin
                    state_next = arrive;
                end else if (elevator_moving) begin
                    state_next = travel;
                end
            end
            travel: begin
                if (!elevator_moving) begin
                    state_next = at_target ? arrive : dispatch;
                end
            end
            arrive: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= idle;
            target_floor <= '0;
        end else begin
            state <= state_next;
            // Head is loaded on the same edge that the queue advances
            if (pop) begin
                target_floor <= head_floor;
            end
        end
    end

    // Take a new floor only with the car stopped and the controller enabled
    assign pop = (state == idle) && enabled && !elevator_moving && !queue_empty;

    assign arrived           = (state == arrive);
    assign activate_elevator = (state == dispatch) && enabled;
    assign direction_up      = (target_floor > current_floor);

    ////////////////////////////////////////////////////////////////////////////
    // Door permissions
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= !elevator_moving && power_switch && door_open_button;
            door_close_allowed <= !elevator_moving && power_switch && door_close_button;
        end
    end

endmodule

// ==== rtl/dispatch_pkg.sv ====
// Dispatch FSM states and request queue sizing.
// At most floor_count requests are pending, so the queue never fills.

package dispatch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Request queue
    ////////////////////////////////////////////////////////////////////////////

    // Entries in the circular buffer
    localparam int queue_depth = 16;

    // Read and write index, wraps at queue_depth
    typedef logic [3:0] queue_ptr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch FSM
    ////////////////////////////////////////////////////////////////////////////

    // idle     waiting for a queued floor
    // dispatch target loaded, car asked to start
    // travel   car under way
    // arrive   one cycle at the target, lamps cleared
    typedef enum logic [1:0] {
        idle     = 2'd0,
        dispatch = 2'd1,
        travel   = 2'd2,
        arrive   = 2'd3
    } dispatch_state_t;

endpackage

// ==== rtl/floor_pkg.sv ====
// Floor numbering and per-floor masks for an 11 floor car.
// Floor 0 is the lowest floor. Values above floor_count-1 never name a floor.

package floor_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Building size
    ////////////////////////////////////////////////////////////////////////////

    // Number of landings served
    localparam int floor_count = 11;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Floor number, 0 to floor_count-1
    typedef logic [3:0] floor_t;

    // One bit per floor, bit 0 is the lowest floor
    // Used for buttons and lamps alike
    typedef logic [floor_count-1:0] floor_mask_t;

endpackage

// ==== rtl/floor_request_top.sv ====
// Floor request controller top level.
// The car motion controller is outside and drives current_floor and elevator_moving.

`timescale 1ns/100ps

module floor_request_top (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  logic                   door_open_button,
    input  logic                   door_close_button,
    input  logic                   emergency_button,
    input  logic                   power_switch,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   elevator_moving,
    output floor_pkg::floor_t      target_floor,
    output logic                   direction_up,
    output logic                   activate_elevator,
    output floor_pkg::floor_mask_t call_button_lights,
    output floor_pkg::floor_mask_t panel_button_lights,
    output logic                   door_open_allowed,
    output logic                   door_close_allowed
);
    import floor_pkg::*;

    logic   new_request;
    floor_t new_floor;
    logic   queue_empty;
    floor_t head_floor;
    logic   pop;
    logic   arrived;

    // Buttons and lamps
    request_latch request_latch_i (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor       (current_floor),
        .power_switch        (power_switch),
        .emergency_button    (emergency_button),
        .arrived             (arrived),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .new_request         (new_request),
        .new_floor           (new_floor)
    );

    // Pending floors in arrival order
    request_queue request_queue_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .new_request (new_request),
        .new_floor   (new_floor),
        .pop         (pop),
        .queue_empty (queue_empty),
        .head_floor  (head_floor)
    );

    dispatch_control dispatch_control_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .queue_empty        (queue_empty),
        .head_floor         (head_floor),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .power_switch       (power_switch),
        .emergency_button   (emergency_button),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .pop                (pop),
        .arrived            (arrived),
        .target_floor       (target_floor),
        .direction_up       (direction_up),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

// ==== rtl/request_latch.sv ====
// Button acceptance and lamp storage.
// One floor is pushed per cycle at most; unaccepted buttons must be held.
// Presses at current_floor are ignored, as are all presses while disabled.

`timescale 1ns/100ps

module request_latch (
    input  logic                   clock,
    input  logic                   reset_n,
    input  floor_pkg::floor_mask_t floor_call_buttons,
    input  floor_pkg::floor_mask_t panel_buttons,
    input  floor_pkg::floor_t      current_floor,
    input  logic                   power_switch,
    input  logic                   emergency_button,
    input  logic                   arrived,
    output floor_pkg::floor_mask_t call_button_lights,
    output floor_pkg::floor_mask_t panel_button_lights,
    output logic                   new_request,
    output floor_pkg::floor_t      new_floor
);
    import floor_pkg::*;

    logic        enabled;
    floor_mask_t cur_mask;
    floor_mask_t lit;
    floor_mask_t qualify;
    floor_mask_t accept_mask;
    floor_mask_t grant;
    floor_mask_t clear_mask;
    logic        pick_valid;
    floor_t      pick_floor;

    ////////////////////////////////////////////////////////////////////////////
    // Accept rule
    ////////////////////////////////////////////////////////////////////////////

    assign enabled  = power_switch && !emergency_button;
    assign cur_mask = floor_mask_t'(1) << current_floor;
    assign lit      = call_button_lights | panel_button_lights;

    // A floor qualifies when pressed on either side, not here and not yet lit
    assign qualify = {floor_count{enabled}} & (floor_call_buttons | panel_buttons)
                   & ~cur_mask & ~lit;

    // Lowest qualifying floor wins, so scan downwards and keep the last hit
    always_comb begin
        pick_valid = 1'b0;
        pick_floor = '0;
        for (int i = floor_count - 1; i >= 0; i--) begin
            if (qualify[i]) begin
                pick_valid = 1'b1;
                pick_floor = floor_t'(i);
            end
        end
    end

    assign accept_mask = pick_valid ? (floor_mask_t'(1) << pick_floor) : '0;

    // Already lit floors may light their other lamp without a new push
    assign grant = accept_mask | ({floor_count{enabled}} & lit & ~cur_mask);

    assign clear_mask = arrived ? cur_mask : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Lamps and push strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            new_request         <= 1'b0;
        end else begin
            call_button_lights  <= (call_button_lights | (floor_call_buttons & grant))
                                 & ~clear_mask;
            panel_button_lights <= (panel_button_lights | (panel_buttons & grant))
                                 & ~clear_mask;
            new_request         <= pick_valid;
        end
    end

    // Floor number only matters while new_request is high
    always_ff @(posedge clock) begin
        new_floor <= pick_floor;
    end

endmodule

// ==== rtl/request_queue.sv ====
// Circular FIFO of accepted floor numbers, oldest at head_floor.
// The head is readable without a pop. A push into a full queue is not guarded.

`timescale 1ns/100ps

module request_queue (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              new_request,
    input  floor_pkg::floor_t new_floor,
    input  logic              pop,
    output logic              queue_empty,
    output floor_pkg::floor_t head_floor
);
    import floor_pkg::*;
    import dispatch_pkg::*;

    floor_t                       entries [queue_depth];
    queue_ptr_t                   wr_ptr;
    queue_ptr_t                   rd_ptr;
    logic [$clog2(queue_depth):0] count;

    // Entry at wr_ptr takes the pushed floor
    always_ff @(posedge clock) begin
        if (new_request) begin
            entries[wr_ptr] <= new_floor;
        end
    end

    // Pointers wrap on their own at queue_depth
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (new_request) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({new_request, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign queue_empty = (count == '0);
    assign head_floor  = entries[rd_ptr];

endmodule

// ==== test/floor_request_assertions.sv ====
// Protocol assertions bound into floor_request_top.
// Checked on the rising clock edge, ignored while reset_n is low.

`timescale 1ns/100ps

module floor_request_assertions (
    input logic clock,
    input logic reset_n,
    input logic pop,
    input logic queue_empty,
    input logic activate_elevator,
    input logic emergency_button,
    input logic elevator_moving,
    input logic door_open_allowed,
    input logic door_close_allowed
);

    // Queue head is only taken when there is one
    pop_needs_entry: assert property (
        @(posedge clock) disable iff (!reset_n) !(pop && queue_empty)
    ) else $error("pop raised while the request queue is empty");

    // Emergency stops any start request at once
    no_start_in_emergency: assert property (
        @(posedge clock) disable iff (!reset_n) emergency_button |-> !activate_elevator
    ) else $error("activate_elevator high during emergency");

    // Door permissions lag the car state by one cycle
    doors_shut_while_moving: assert property (
        @(posedge clock) disable iff (!reset_n)
        elevator_moving |=> (!door_open_allowed && !door_close_allowed)
    ) else $error("door permission granted after the car was moving");

endmodule

// ==== test/floor_request_clock.sv ====
// Clock and reset source for the testbench.
// 100 ns period, reset_n held low for the first 16 rising edges.

`timescale 1ns/100ps

module floor_request_clock (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

// ==== test/floor_request_tb.sv ====
// Directed testbench for the floor request controller.
// A simple car model steps one floor every 4 cycles toward target_floor.
// Inputs change on the rising edge, outputs are checked on the falling edge.

`timescale 1ns/100ps

module floor_request_tb;
    import floor_pkg::*;

    localparam int wait_limit = 200;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    floor_t      current_floor   = '0;
    logic        elevator_moving = 1'b0;
    floor_t      target_floor;
    logic        direction_up;
    logic        activate_elevator;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Requests from the test process to move the car without travel
    logic   place_request = 1'b0;
    floor_t place_floor   = '0;
    int     step_count    = 0;

    string current_test;
    int    check_count = 0;
    int    error_count = 0;
    int    test_errors = 0;

    floor_request_clock clock_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_request_top floor_request_top_i (.*);

    bind floor_request_top floor_request_assertions floor_request_assertions_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .pop                (pop),
        .queue_empty        (queue_empty),
        .activate_elevator  (activate_elevator),
        .emergency_button   (emergency_button),
        .elevator_moving    (elevator_moving),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Car model
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (place_request) begin
            current_floor   <= place_floor;
            elevator_moving <= 1'b0;
        end else if (!elevator_moving) begin
            if (activate_elevator && target_floor != current_floor) begin
                elevator_moving <= 1'b1;
                step_count      <= 0;
            end
        end else if (current_floor == target_floor) begin
            elevator_moving <= 1'b0;
        end else if (step_count == 3) begin
            step_count    <= 0;
            current_floor <= direction_up ? current_floor + 4'd1 : current_floor - 4'd1;
        end else begin
            step_count <= step_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic floor_mask_t floor_bit(input floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

    task automatic start_test(input string name);
        current_test = name;
        test_errors  = 0;
    endtask

    task automatic end_test();
        $display("%s: %s", current_test, (test_errors == 0) ? "ok" : "errors seen");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     current_test, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", current_test, what);
        error_count++;
        test_errors++;
    endtask

    // One cycle press of any mix of hall and panel buttons
    task automatic press(input floor_mask_t calls, input floor_mask_t panel);
        @(posedge clock);
        floor_call_buttons <= calls;
        panel_buttons      <= panel;
        @(posedge clock);
        floor_call_buttons <= '0;
        panel_buttons      <= '0;
    endtask

    task automatic place_car(input floor_t f);
        @(posedge clock);
        place_request <= 1'b1;
        place_floor   <= f;
        @(posedge clock);
        place_request <= 1'b0;
    endtask

    task automatic wait_activate(input floor_t exp_target, input logic exp_up);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!activate_elevator && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!activate_elevator) begin
            report_timeout("activate_elevator never rose");
        end else begin
            check_value("target_floor", int'(exp_target), int'(target_floor));
            check_value("direction_up", int'(exp_up), int'(direction_up));
        end
    endtask

    // Lamps of a floor go dark only after the arrive cycle
    task automatic wait_lamps_clear(input floor_t f);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while ((call_button_lights[f] || panel_button_lights[f]) && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (call_button_lights[f] || panel_button_lights[f]) begin
            report_timeout("lamps of the target floor never cleared");
        end else begin
            check_value("current_floor at arrival", int'(f), int'(current_floor));
            check_value("elevator_moving at arrival", 0, int'(elevator_moving));
        end
    endtask

    task automatic wait_moving();
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (!elevator_moving && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!elevator_moving) begin
            report_timeout("car never started moving");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        start_test("reset_state");
        @(negedge clock);
        check_value("call_button_lights", 0, int'(call_button_lights));
        check_value("panel_button_lights", 0, int'(panel_button_lights));
        check_value("activate_elevator", 0, int'(activate_elevator));
        check_value("door_open_allowed", 0, int'(door_open_allowed));
        check_value("door_close_allowed", 0, int'(door_close_allowed));
        end_test();
    endtask

    task automatic test_single_request();
        start_test("single_request");
        place_car(4'd0);
        press('0, floor_bit(4'd6));
        @(negedge clock);
        check_value("panel lamp 6", 1, int'(panel_button_lights[6]));
        wait_activate(4'd6, 1'b1);
        wait_lamps_clear(4'd6);
        end_test();
    endtask

    task automatic test_press_here();
        start_test("press_here");
        @(posedge clock);
        floor_call_buttons <= floor_bit(current_floor);
        panel_buttons      <= floor_bit(current_floor);
        repeat (4) begin
            @(negedge clock);
            check_value("call_button_lights", 0, int'(call_button_lights));
            check_value("panel_button_lights", 0, int'(panel_button_lights));
            check_value("activate_elevator", 0, int'(activate_elevator));
        end
        @(posedge clock);
        floor_call_buttons <= '0;
        panel_buttons      <= '0;
        end_test();
    endtask

    task automatic test_arrival_order();
        start_test("arrival_order");
        place_car(4'd5);
        // Car busy with floor 6 so that 9 and 2 both wait in the queue
        press('0, floor_bit(4'd6));
        wait_activate(4'd6, 1'b1);
        wait_moving();
        press(floor_bit(4'd9), '0);
        press('0, floor_bit(4'd2));
        wait_lamps_clear(4'd6);
        wait_activate(4'd9, 1'b1);
        wait_lamps_clear(4'd9);
        wait_activate(4'd2, 1'b0);
        wait_lamps_clear(4'd2);
        end_test();
    endtask

    task automatic test_disabled();
        start_test("disabled");
        // Accepted just before the emergency, so it sits in the queue
        @(posedge clock);
        panel_buttons <= floor_bit(4'd4);
        @(posedge clock);
        panel_buttons    <= '0;
        emergency_button <= 1'b1;
        repeat (10) begin
            @(negedge clock);
            check_value("activate_elevator in emergency", 0, int'(activate_elevator));
        end
        check_value("queued panel lamp 4", 1, int'(panel_button_lights[4]));
        press('0, floor_bit(4'd8));
        @(negedge clock);
        check_value("panel lamp 8 in emergency", 0, int'(panel_button_lights[8]));
        @(posedge clock);
        emergency_button <= 1'b0;
        power_switch     <= 1'b0;
        press(floor_bit(4'd8), floor_bit(4'd8));
        repeat (6) begin
            @(negedge clock);
            check_value("call lamp 8 with power off", 0, int'(call_button_lights[8]));
            check_value("activate_elevator with power off", 0, int'(activate_elevator));
        end
        @(posedge clock);
        power_switch <= 1'b1;
        wait_activate(4'd4, 1'b1);
        wait_lamps_clear(4'd4);
        end_test();
    endtask

    task automatic test_door();
        int cycles;
        start_test("door");
        @(posedge clock);
        door_open_button  <= 1'b1;
        door_close_button <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("door_open_allowed stopped", 1, int'(door_open_allowed));
        check_value("door_close_allowed stopped", 1, int'(door_close_allowed));
        @(posedge clock);
        door_open_button  <= 1'b0;
        door_close_button <= 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_value("door_open_allowed released", 0, int'(door_open_allowed));
        check_value("door_close_allowed released", 0, int'(door_close_allowed));
        @(posedge clock);
        door_open_button <= 1'b1;
        press('0, floor_bit(4'd7));
        wait_moving();
        cycles = 0;
        // First moving cycle still shows the permission from the stopped cycle
        @(negedge clock);
        while (elevator_moving && cycles < wait_limit) begin
            check_value("door_open_allowed moving", 0, int'(door_open_allowed));
            @(negedge clock);
            cycles++;
        end
        if (elevator_moving) begin
            report_timeout("car never stopped");
        end
        @(posedge clock);
        door_open_button <= 1'b0;
        wait_lamps_clear(4'd7);
        end_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_button   = 1'b0;
        door_close_button  = 1'b0;
        emergency_button   = 1'b0;
        power_switch       = 1'b1;
        cycles             = 0;
        @(posedge clock);
        while (!reset_n && cycles < wait_limit) begin
            @(posedge clock);
            cycles++;
        end
        if (!reset_n) begin
            current_test = "reset";
            report_timeout("reset_n was never released");
        end else begin
            test_reset_state();
            test_single_request();
            test_press_here();
            test_arrival_order();
            test_disabled();
            test_door();
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
